// ==== sources.f ====
rtl/rv_pipe_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/exe_stage.sv
rtl/writeback_stage.sv
rtl/rv_alu_pipe_top.sv
testbench/tb_rv_alu_pipe.sv

// ==== testbench/tb_rv_alu_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_alu_pipe;
  import rv_pipe_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RAND_COUNT = 200;
  localparam int MAX_GAP    = 3;
  // directed tests plus the random stream at its longest
  localparam int RUN_CYCLES = 200 + RAND_COUNT * (MAX_GAP + 1);

  logic      clk;
  logic      reset_i;
  inst_t     inst_i;
  logic      inst_valid_i;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;
  logic      illegal_o;

  int        cyc;
  int        err_value;
  int        err_pulse;
  word_t     model [REG_COUNT];
  // expected pulses in issue order
  int        exp_due [$];
  logic      exp_ill [$];
  reg_addr_t exp_rd [$];
  word_t     exp_val [$];

  rv_alu_pipe_top rv_alu_pipe_top_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #((RUN_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the pipeline did not finish the tests in time");
    $display("Simulation FAILED");
    $finish;
  end

  // ==============================
  // helpers
  // ==============================
  task automatic compare(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_value++;
    end
  endtask

  function automatic inst_t enc_r(input logic [2:0] f3, input logic alt,
                                  input reg_addr_t rd, input reg_addr_t rs1,
                                  input reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic inst_t enc_i(input logic [2:0] f3, input logic [11:0] imm,
                                  input reg_addr_t rd, input reg_addr_t rs1);
    return {imm, rs1, f3, rd, OPCODE_OP_IMM};
  endfunction

  // RV32I result computed on the in-order register model
  function automatic word_t expected_result(input inst_t in);
    word_t a;
    word_t b;
    logic  imm_form;
    a        = model[in[19:15]];
    imm_form = (in[6:0] == OPCODE_OP_IMM);
    b        = imm_form ? {{20{in[31]}}, in[31:20]} : model[in[24:20]];
    case (in[14:12])
      3'd0:    return (!imm_form && in[30]) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return in[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic issue(input inst_t in);
    reg_addr_t rd;
    word_t     res;
    @(posedge clk);
    #2;
    inst_i       = in;
    inst_valid_i = 1'b1;
    rd           = in[11:7];
    if (in[6:0] != OPCODE_OP && in[6:0] != OPCODE_OP_IMM) begin
      exp_due.push_back(cyc + 3);
      exp_ill.push_back(1'b1);
      exp_rd.push_back('0);
      exp_val.push_back('0);
    end else if (rd != '0) begin
      res       = expected_result(in);
      model[rd] = res;
      exp_due.push_back(cyc + 3);
      exp_ill.push_back(1'b0);
      exp_rd.push_back(rd);
      exp_val.push_back(res);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      inst_valid_i = 1'b0;
      // garbage while invalid must be ignored
      inst_i = '0;
    end
  endtask

  task automatic drain();
    while (exp_due.size() != 0) idle(1);
    idle(2);
  endtask

  task automatic drop_front();
    exp_due.delete(0);
    exp_ill.delete(0);
    exp_rd.delete(0);
    exp_val.delete(0);
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!reset_i) begin
      if (exp_due.size() != 0 && exp_due[0] == cyc) begin
        if (exp_ill[0] && !(illegal_o && !wb_valid_o)) begin
          $display("missing illegal pulse at %0t ns", $time);
          err_pulse++;
        end else if (!exp_ill[0] && !(wb_valid_o && !illegal_o)) begin
          $display("missing write-back pulse for x%0d at %0t ns", exp_rd[0], $time);
          err_pulse++;
        end else if (!exp_ill[0]) begin
          compare("wb_rd_o", word_t'(wb_rd_o), word_t'(exp_rd[0]));
          compare("wb_data_o", wb_data_o, exp_val[0]);
        end
        drop_front();
      end else if (wb_valid_o || illegal_o) begin
        $display("unexpected pulse at %0t ns when none was due", $time);
        err_pulse++;
      end
    end
  end

  // ==============================
  // directed tests
  // ==============================
  task automatic reset_state_test();
    idle(10);
    for (int r = 1; r <= 5; r++) issue(enc_r(F3_ADD_SUB, 1'b0, r, 0, 0));
    drain();
  endtask

  task automatic imm_ops_test();
    issue(enc_i(F3_ADD_SUB, -12'sd5, 1, 0));
    issue(enc_i(F3_ADD_SUB, 12'h7ff, 2, 0));
    issue(enc_i(F3_ADD_SUB, 12'h800, 3, 0));
    issue(enc_i(F3_SLT, -12'sd4, 4, 1));
    issue(enc_i(F3_SLTU, 12'hfff, 5, 1));
    issue(enc_i(F3_XOR, 12'hfff, 6, 2));
    issue(enc_i(F3_OR, 12'h00f, 7, 3));
    issue(enc_i(F3_AND, 12'h7f0, 8, 1));
    issue(enc_i(F3_SLL, 12'd20, 9, 2));
    issue(enc_i(F3_SRL_SRA, 12'd28, 10, 1));
    issue(enc_i(F3_SRL_SRA, 12'h401, 11, 1));
    issue(enc_i(F3_SRL_SRA, 12'h41f, 12, 3));
    drain();
  endtask

  task automatic reg_ops_test();
    issue(enc_r(F3_ADD_SUB, 1'b0, 13, 9, 9));
    issue(enc_r(F3_ADD_SUB, 1'b1, 14, 0, 2));
    issue(enc_r(F3_SLL, 1'b0, 15, 2, 1));
    issue(enc_r(F3_SLT, 1'b0, 16, 1, 2));
    issue(enc_r(F3_SLTU, 1'b0, 17, 1, 2));
    issue(enc_r(F3_XOR, 1'b0, 18, 1, 3));
    issue(enc_r(F3_SRL_SRA, 1'b0, 19, 1, 2));
    issue(enc_r(F3_SRL_SRA, 1'b1, 20, 1, 1));
    issue(enc_r(F3_OR, 1'b0, 21, 3, 9));
    issue(enc_r(F3_AND, 1'b0, 22, 1, 6));
    drain();
  endtask

  // distances 1, 2 and 3 back to back
  task automatic forwarding_test();
    issue(enc_i(F3_ADD_SUB, 12'd7, 24, 0));
    issue(enc_r(F3_ADD_SUB, 1'b0, 25, 24, 24));
    issue(enc_r(F3_ADD_SUB, 1'b1, 26, 25, 24));
    issue(enc_r(F3_ADD_SUB, 1'b0, 27, 24, 26));
    issue(enc_r(F3_SLL, 1'b0, 28, 25, 27));
    drain();
  endtask

  task automatic x0_illegal_test();
    issue(enc_i(F3_ADD_SUB, 12'd5, 0, 1));
    issue(enc_r(F3_ADD_SUB, 1'b0, 29, 0, 0));
    // load opcode with rd = x1
    issue(32'h0000_2083);
    issue(enc_r(F3_ADD_SUB, 1'b0, 30, 1, 0));
    drain();
  endtask

  task automatic random_test();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (int n = 0; n < RAND_COUNT; n++) begin
      f3  = 3'($urandom);
      alt = $urandom % 2;
      if ($urandom % 2) begin
        issue(enc_r(f3, alt && (f3 == 3'd0 || f3 == 3'd5), $urandom, $urandom, $urandom));
      end else begin
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};
        issue(enc_i(f3, imm, $urandom, $urandom));
      end
      idle($urandom % (MAX_GAP + 1));
    end
    drain();
  endtask

  initial begin
    void'($urandom(32'h681e_7bac));
    cyc          = 0;
    err_value    = 0;
    err_pulse    = 0;
    reset_i      = 1'b1;
    inst_i       = NOP_INST;
    inst_valid_i = 1'b0;
    for (int r = 0; r < REG_COUNT; r++) model[r] = '0;
    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;

    reset_state_test();
    imm_ops_test();
    reg_ops_test();
    forwarding_test();
    x0_illegal_test();
    random_test();

    $display("errors: %0d value mismatches, %0d pulse errors", err_value, err_pulse);
    if (err_value + err_pulse == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/rv_alu_pipe_top.sv ====
`timescale 1ns/1ps

module rv_alu_pipe_top (
  input  logic                   clk,
  input  logic                   reset_i,
  input  rv_pipe_pkg::inst_t     inst_i,
  input  logic                   inst_valid_i,
  output logic                   wb_valid_o,
  output rv_pipe_pkg::reg_addr_t wb_rd_o,
  output rv_pipe_pkg::word_t     wb_data_o,
  output logic                   illegal_o
);
  import rv_pipe_pkg::*;

  // ==============================
  // decode side
  // ==============================
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  logic      dec_use_imm;
  alu_op_t   dec_alu_op;
  logic      dec_valid;
  logic      dec_illegal;
  word_t     rf_rdata1;
  word_t     rf_rdata2;

  // execute side
  logic      exe_valid;
  logic      exe_illegal;
  reg_addr_t exe_rd;
  word_t     exe_result;

  inst_decoder inst_decoder_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .rs1_addr_o   (dec_rs1),
    .rs2_addr_o   (dec_rs2),
    .rd_o         (dec_rd),
    .imm_o        (dec_imm),
    .use_imm_o    (dec_use_imm),
    .alu_op_o     (dec_alu_op),
    .valid_o      (dec_valid),
    .illegal_o    (dec_illegal)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .we_i     (wb_valid_o),
    .waddr_i  (wb_rd_o),
    .wdata_i  (wb_data_o)
  );

  exe_stage exe_stage_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .valid_i    (dec_valid),
    .illegal_i  (dec_illegal),
    .use_imm_i  (dec_use_imm),
    .alu_op_i   (dec_alu_op),
    .rs1_addr_i (dec_rs1),
    .rs2_addr_i (dec_rs2),
    .rd_i       (dec_rd),
    .rdata1_i   (rf_rdata1),
    .rdata2_i   (rf_rdata2),
    .imm_i      (dec_imm),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .valid_o    (exe_valid),
    .illegal_o  (exe_illegal),
    .rd_o       (exe_rd),
    .result_o   (exe_result)
  );

  writeback_stage writeback_stage_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .valid_i    (exe_valid),
    .illegal_i  (exe_illegal),
    .rd_i       (exe_rd),
    .result_i   (exe_result),
    .wb_valid_o (wb_valid_o),
    .illegal_o  (illegal_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic                   illegal_i,
  input  rv_pipe_pkg::reg_addr_t rd_i,
  input  rv_pipe_pkg::word_t     result_i,
  output logic                   wb_valid_o,
  output logic                   illegal_o,
  output rv_pipe_pkg::reg_addr_t wb_rd_o,
  output rv_pipe_pkg::word_t     wb_data_o
);
  import rv_pipe_pkg::*;

  logic      wb_valid_q;
  logic      illegal_q;
  reg_addr_t rd_q;
  word_t     data_q;

  // writes to x0 retire without a pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
      illegal_q  <= 1'b0;
    end else begin
      wb_valid_q <= valid_i && (rd_i != '0);
      illegal_q  <= illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= rd_i;
    data_q <= result_i;
  end

  // also the register-file write port and forwarding source
  assign wb_valid_o = wb_valid_q;
  assign illegal_o  = illegal_q;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_q;

endmodule

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic                   illegal_i,
  input  logic                   use_imm_i,
  input  rv_pipe_pkg::alu_op_t   alu_op_i,
  input  rv_pipe_pkg::reg_addr_t rs1_addr_i,
  input  rv_pipe_pkg::reg_addr_t rs2_addr_i,
  input  rv_pipe_pkg::reg_addr_t rd_i,
  input  rv_pipe_pkg::word_t     rdata1_i,
  input  rv_pipe_pkg::word_t     rdata2_i,
  input  rv_pipe_pkg::word_t     imm_i,
  input  logic                   wb_valid_i,
  input  rv_pipe_pkg::reg_addr_t wb_rd_i,
  input  rv_pipe_pkg::word_t     wb_data_i,
  output logic                   valid_o,
  output logic                   illegal_o,
  output rv_pipe_pkg::reg_addr_t rd_o,
  output rv_pipe_pkg::word_t     result_o
);
  import rv_pipe_pkg::*;

  // decode-to-execute register
  logic      valid_q;
  logic      illegal_q;
  logic      use_imm_q;
  alu_op_t   alu_op_q;
  reg_addr_t rs1_q;
  reg_addr_t rs2_q;
  reg_addr_t rd_q;
  word_t     rdata1_q;
  word_t     rdata2_q;
  word_t     imm_q;

  logic      fwd1;
  logic      fwd2;
  word_t     op1;
  word_t     rs2_val;
  word_t     op2;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= valid_i;
      illegal_q <= illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    use_imm_q <= use_imm_i;
    alu_op_q  <= alu_op_i;
    rs1_q     <= rs1_addr_i;
    rs2_q     <= rs2_addr_i;
    rd_q      <= rd_i;
    rdata1_q  <= rdata1_i;
    rdata2_q  <= rdata2_i;
    imm_q     <= imm_i;
  end

  // ==============================
  // forwarding from write-back
  // ==============================
  assign fwd1 = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs1_q);
  assign fwd2 = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs2_q);

  assign op1     = fwd1 ? wb_data_i : rdata1_q;
  assign rs2_val = fwd2 ? wb_data_i : rdata2_q;

  // OP-IMM takes the immediate
  assign op2 = use_imm_q ? imm_q : rs2_val;

  alu alu_inst (
    .alu_op_i (alu_op_q),
    .op1_i    (op1),
    .op2_i    (op2),
    .result_o (result_o)
  );

  assign valid_o   = valid_q;
  assign illegal_o = illegal_q;
  assign rd_o      = rd_q;

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  logic                   clk,
  input  logic                   reset_i,
  input  rv_pipe_pkg::inst_t     inst_i,
  input  logic                   inst_valid_i,
  output rv_pipe_pkg::reg_addr_t rs1_addr_o,
  output rv_pipe_pkg::reg_addr_t rs2_addr_o,
  output rv_pipe_pkg::reg_addr_t rd_o,
  output rv_pipe_pkg::word_t     imm_o,
  output logic                   use_imm_o,
  output rv_pipe_pkg::alu_op_t   alu_op_o,
  output logic                   valid_o,
  output logic                   illegal_o
);
  import rv_pipe_pkg::*;

  inst_t      inst_q;
  logic       valid_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b30;
  logic       is_op;
  logic       is_op_imm;
  logic       is_shift;

  // instruction register with a bubble on reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      inst_q  <= NOP_INST;
      valid_q <= 1'b0;
    end else begin
      inst_q  <= inst_i;
      valid_q <= inst_valid_i;
    end
  end

  // field extraction
  assign opcode     = inst_q[6:0];
  assign funct3     = inst_q[14:12];
  assign funct7_b30 = inst_q[30];
  assign rd_o       = inst_q[11:7];
  assign rs1_addr_o = inst_q[19:15];
  assign rs2_addr_o = inst_q[24:20];

  assign is_op     = (opcode == OPCODE_OP);
  assign is_op_imm = (opcode == OPCODE_OP_IMM);
  assign is_shift  = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);
  assign use_imm_o = is_op_imm;

  // I-type immediate or shamt for shifts
  assign imm_o = is_shift ? {{(XLEN-5){1'b0}}, inst_q[24:20]}
                          : {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};

  // bit 30 picks sub only for register ops
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_op_o = (is_op && funct7_b30) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_o = ALU_SLL;
      F3_SLT:     alu_op_o = ALU_SLT;
      F3_SLTU:    alu_op_o = ALU_SLTU;
      F3_XOR:     alu_op_o = ALU_XOR;
      F3_SRL_SRA: alu_op_o = funct7_b30 ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_o = ALU_OR;
      F3_AND:     alu_op_o = ALU_AND;
      default:    alu_op_o = ALU_ADD;
    endcase
  end

  // unsupported opcode turns into a reported bubble
  assign valid_o   = valid_q && (is_op || is_op_imm);
  assign illegal_o = valid_q && !(is_op || is_op_imm);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                   clk,
  input  logic                   reset_i,
  input  rv_pipe_pkg::reg_addr_t raddr1_i,
  input  rv_pipe_pkg::reg_addr_t raddr2_i,
  output rv_pipe_pkg::word_t     rdata1_o,
  output rv_pipe_pkg::word_t     rdata2_o,
  input  logic                   we_i,
  input  rv_pipe_pkg::reg_addr_t waddr_i,
  input  rv_pipe_pkg::word_t     wdata_i
);
  import rv_pipe_pkg::*;

  word_t regs [REG_COUNT];
  logic  wr_en;

  // x0 never gets written
  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through for same-cycle read
  assign rdata1_o = (wr_en && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (wr_en && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  rv_pipe_pkg::alu_op_t alu_op_i,
  input  rv_pipe_pkg::word_t   op1_i,
  input  rv_pipe_pkg::word_t   op2_i,
  output rv_pipe_pkg::word_t   result_o
);
  import rv_pipe_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = op2_i[4:0];
  assign lt_signed   = $signed(op1_i) < $signed(op2_i);
  assign lt_unsigned = op1_i < op2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = op1_i + op2_i;
      ALU_SUB:  result_o = op1_i - op2_i;
      ALU_SLL:  result_o = op1_i << shamt;
      // compares give 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result_o = op1_i ^ op2_i;
      ALU_SRL:  result_o = op1_i >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  result_o = word_t'($signed(op1_i) >>> shamt);
      ALU_OR:   result_o = op1_i | op2_i;
      ALU_AND:  result_o = op1_i & op2_i;
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== rtl/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_AW    = $clog2(REG_COUNT);

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [31:0]       inst_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // ==============================
  // encodings
  // ==============================
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  // funct3 by meaning for both OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h00000013;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

endpackage
